/* design/exPkg.sv */
/*
 Execute back end shared definitions
 Widths, queue depths, micro-op commands and the packed records
 that travel between EX1, EX2, the retire stream and the AXI4-Lite port
*/
package exPkg;

	localparam int regIdW = 4; // 16 GPRs
	localparam int dataW = 64;
	localparam int addrW = 32;
	localparam int stageDepth = 4; // EX1 to EX2 buffer
	localparam int retireDepth = 2;
	localparam int mulCycles = 3; // EX2 hold cycles on MUL3
	localparam int holdW = 3; // Saturating hold counter
	localparam int pendW = 3; // Covers EX1 register plus full stage queue
	localparam logic [1:0] respOkay = 2'b00;

	typedef enum logic [3:0] {
		NOP = 4'd0,
		MOV_IR = 4'd1,
		ALU3 = 4'd2,
		ALUCMP = 4'd3,
		MUL3 = 4'd4,
		MOV_RM = 4'd5, // Store
		MOV_MR = 4'd6 // Load
	} exCmd;

	typedef struct packed {
		exCmd cmd;
		logic [1:0] ixt; // Op form
		logic [1:0] cond; // 00 always, 01 never, 10 if T, 11 if not T
		logic [regIdW-1:0] rs; // Source A, ALU / base
		logic [regIdW-1:0] rt; // Source B
		logic [regIdW-1:0] rm; // Dest or store data
		logic [31:0] imm;
	} exUop;

	typedef struct packed {
		exCmd cmd; // NOP when predicate failed
		exCmd origCmd;
		logic [1:0] ixt;
		logic [regIdW-1:0] rm;
		logic [dataW-1:0] operandA;
		logic [dataW-1:0] operandB;
		logic [dataW-1:0] aluResult;
		logic [addrW-1:0] memAddr;
		logic [dataW-1:0] storeData;
		logic newT;
		logic tWriteEn;
	} exStageEntry;

	typedef struct packed {
		exCmd cmd;
		logic writes;
		logic [regIdW-1:0] regId;
		logic [dataW-1:0] value;
		logic tWrite;
		logic tValue;
		logic fault;
	} exRetire;

	typedef struct packed {
		logic awvalid;
		logic [addrW-1:0] awaddr;
		logic wvalid;
		logic [dataW-1:0] wdata;
		logic [dataW/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [addrW-1:0] araddr;
		logic rready;
	} axiLiteReq;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [dataW-1:0] rdata;
		logic [1:0] rresp;
	} axiLiteRsp;

	// Ops that leave a value in rm
	function automatic logic writesReg(exCmd cmd);
		return cmd inside {MOV_IR, ALU3, MUL3, MOV_MR};
	endfunction

	function automatic logic isKnown(exCmd cmd);
		return cmd inside {NOP, MOV_IR, ALU3, ALUCMP, MUL3, MOV_RM, MOV_MR};
	endfunction

endpackage

/* design/exRegFile.sv */
/*
 GPR file and T status flag
 Three combinational read ports for EX1, one write port from EX2
*/
`timescale 1ns/1ns
module exRegFile (
	input logic clock,
	input logic arstN,
	input logic [exPkg::regIdW-1:0] readIdA,
	input logic [exPkg::regIdW-1:0] readIdB,
	input logic [exPkg::regIdW-1:0] readIdC,
	output logic [exPkg::dataW-1:0] readValA,
	output logic [exPkg::dataW-1:0] readValB,
	output logic [exPkg::dataW-1:0] readValC,
	output logic tFlag,
	input logic writeEn,
	input logic [exPkg::regIdW-1:0] writeId,
	input logic [exPkg::dataW-1:0] writeVal,
	input logic tWrite,
	input logic tValue
);

	logic [exPkg::dataW-1:0] regs [2**exPkg::regIdW];

	assign readValA = regs[readIdA];
	assign readValB = regs[readIdB];
	assign readValC = regs[readIdC]; // Store data

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**exPkg::regIdW; i++) begin
				regs[i] <= '0;
			end
			tFlag <= 1'b0;
		end else begin
			if (writeEn)
				regs[writeId] <= writeVal;
			if (tWrite)
				tFlag <= tValue;
		end
	end

endmodule

/* design/exIssue.sv */
/*
 EX1 issue stage
 Predicate check, operand read, ALU and address compute,
 pending-write scoreboard that stalls on register and T hazards
*/
`timescale 1ns/1ns
module exIssue (
	input logic clock,
	input logic arstN,
	input logic uopValid,
	input exPkg::exUop uop,
	output logic uopReady,
	output logic [exPkg::regIdW-1:0] readIdA,
	output logic [exPkg::regIdW-1:0] readIdB,
	output logic [exPkg::regIdW-1:0] readIdC,
	input logic [exPkg::dataW-1:0] readValA,
	input logic [exPkg::dataW-1:0] readValB,
	input logic [exPkg::dataW-1:0] readValC,
	input logic tFlag,
	output logic stageValid,
	output exPkg::exStageEntry stageEntry,
	input logic stageReady,
	input logic clearEn,
	input logic [exPkg::regIdW-1:0] clearId,
	input logic clearT
);

	logic [exPkg::pendW-1:0] regPend [2**exPkg::regIdW];
	logic [exPkg::pendW-1:0] tPend;
	logic issueLive; // Opens uopReady one cycle after reset
	logic predOk;
	logic srcHazard;
	logic tHazard;
	logic accept;
	logic setReg;
	logic setT;
	logic [exPkg::dataW-1:0] immExt;
	logic [exPkg::addrW-1:0] addrSum;
	exPkg::exStageEntry nextEntry;

	assign readIdA = uop.rs;
	assign readIdB = uop.rt;
	assign readIdC = uop.rm;
	assign immExt = {{(exPkg::dataW-32){uop.imm[31]}}, uop.imm};
	assign addrSum = readValA[exPkg::addrW-1:0] + immExt[exPkg::addrW-1:0];

	always_comb begin
		case (uop.cond)
			2'b00: predOk = 1'b1;
			2'b01: predOk = 1'b0;
			2'b10: predOk = tFlag;
			default: predOk = !tFlag;
		endcase
	end

	always_comb begin
		srcHazard = 1'b0;
		if (uop.cmd inside {exPkg::ALU3, exPkg::ALUCMP, exPkg::MUL3, exPkg::MOV_RM, exPkg::MOV_MR})
			srcHazard = srcHazard || regPend[uop.rs] != '0; // Base or source A
		if (uop.cmd inside {exPkg::ALU3, exPkg::ALUCMP, exPkg::MUL3})
			srcHazard = srcHazard || regPend[uop.rt] != '0;
		if (uop.cmd == exPkg::MOV_RM)
			srcHazard = srcHazard || regPend[uop.rm] != '0; // Store data
	end

	assign tHazard = uop.cond[1] && tPend != '0; // Predicate needs settled T
	assign uopReady = issueLive && !tHazard && !(predOk && srcHazard)
		&& (!stageValid || stageReady);
	assign accept = uopValid && uopReady;
	assign setReg = accept && predOk && exPkg::writesReg(uop.cmd);
	assign setT = accept && predOk && uop.cmd == exPkg::ALUCMP;

	always_comb begin
		nextEntry = '0;
		nextEntry.origCmd = uop.cmd;
		nextEntry.cmd = predOk ? uop.cmd : exPkg::NOP; // Failed predicate squashes
		nextEntry.ixt = uop.ixt;
		nextEntry.rm = uop.rm;
		nextEntry.operandA = readValA;
		nextEntry.operandB = readValB;
		nextEntry.storeData = readValC;
		nextEntry.memAddr = {addrSum[exPkg::addrW-1:3], 3'b000}; // 8-byte aligned
		case (nextEntry.cmd)
			exPkg::MOV_IR: nextEntry.aluResult = immExt;
			exPkg::ALU3: begin
				case (uop.ixt)
					2'b00: nextEntry.aluResult = readValA + readValB;
					2'b01: nextEntry.aluResult = readValA - readValB;
					2'b10: nextEntry.aluResult = readValA & readValB;
					default: nextEntry.aluResult = readValA ^ readValB;
				endcase
			end
			exPkg::ALUCMP: begin
				nextEntry.tWriteEn = 1'b1;
				nextEntry.newT = uop.ixt[0] ? ($signed(readValA) > $signed(readValB))
					: (readValA == readValB);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			issueLive <= 1'b0;
			stageValid <= 1'b0;
			tPend <= '0;
			for (int i = 0; i < 2**exPkg::regIdW; i++) begin
				regPend[i] <= '0;
			end
		end else begin
			issueLive <= 1'b1;
			if (accept)
				stageValid <= 1'b1;
			else if (stageReady)
				stageValid <= 1'b0;
			tPend <= tPend + exPkg::pendW'(setT) - exPkg::pendW'(clearT);
			for (int i = 0; i < 2**exPkg::regIdW; i++) begin
				regPend[i] <= regPend[i]
					+ exPkg::pendW'(setReg && uop.rm == exPkg::regIdW'(i))
					- exPkg::pendW'(clearEn && clearId == exPkg::regIdW'(i));
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			stageEntry <= nextEntry;
	end

endmodule

/* design/exStageQueue.sv */
/*
 Stage queue
 Circular FIFO with valid/ready on both sides, payload type set per instance
*/
`timescale 1ns/1ns
module exStageQueue #(
	parameter type payloadT = logic,
	parameter int depth = 4
) (
	input logic clock,
	input logic arstN,
	input logic inValid,
	input payloadT inData,
	output logic inReady,
	output logic outValid,
	output payloadT outData,
	input logic outReady
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	payloadT mem [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic push;
	logic pop;

	assign outValid = count != '0;
	assign outData = mem[rdPtr];
	assign inReady = count != cntW'(depth) || outReady; // Push while full if popping
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + cntW'(push) - cntW'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wrPtr] <= inData;
	end

endmodule

/* design/exMemMaster.sv */
/*
 AXI4-Lite memory master
 One load or store in flight, start pulse in, done pulse out
*/
`timescale 1ns/1ns
module exMemMaster (
	input logic clock,
	input logic arstN,
	input logic start,
	input logic isWrite,
	input logic [exPkg::addrW-1:0] addr,
	input logic [exPkg::dataW-1:0] wdata,
	output logic done,
	output logic error,
	output logic [exPkg::dataW-1:0] rdata,
	output exPkg::axiLiteReq memReq,
	input exPkg::axiLiteRsp memRsp
);

	typedef enum logic [1:0] {memIdle, memWrite, memRead} memStateT;

	memStateT state;
	logic awValid;
	logic wValid;
	logic arValid;
	logic [exPkg::addrW-1:0] addrQ;
	logic [exPkg::dataW-1:0] wdataQ;

	always_comb begin
		memReq = '0;
		memReq.awvalid = awValid;
		memReq.awaddr = addrQ;
		memReq.wvalid = wValid;
		memReq.wdata = wdataQ;
		memReq.wstrb = '1; // Full 64-bit words only
		memReq.bready = state == memWrite;
		memReq.arvalid = arValid;
		memReq.araddr = addrQ;
		memReq.rready = state == memRead;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= memIdle;
			awValid <= 1'b0;
			wValid <= 1'b0;
			arValid <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				memIdle: begin
					if (start) begin
						state <= isWrite ? memWrite : memRead;
						awValid <= isWrite; // AW and W raised together
						wValid <= isWrite;
						arValid <= !isWrite;
					end
				end
				memWrite: begin
					if (memRsp.awready)
						awValid <= 1'b0;
					if (memRsp.wready)
						wValid <= 1'b0;
					if (memRsp.bvalid) begin
						state <= memIdle;
						done <= 1'b1;
						error <= memRsp.bresp != exPkg::respOkay;
					end
				end
				memRead: begin
					if (memRsp.arready)
						arValid <= 1'b0;
					if (memRsp.rvalid) begin
						state <= memIdle;
						done <= 1'b1;
						error <= memRsp.rresp != exPkg::respOkay;
					end
				end
				default: state <= memIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == memIdle && start) begin
			addrQ <= addr;
			wdataQ <= wdata;
		end
		if (state == memRead && memRsp.rvalid)
			rdata <= memRsp.rdata; // Held for EX2 until next read
	end

endmodule

/* design/exComplete.sv */
/*
 EX2 completion stage
 Holds the queue head on multiply and memory work, selects the result,
 writes back, clears the scoreboard and pushes the retire record
*/
`timescale 1ns/1ns
module exComplete (
	input logic clock,
	input logic arstN,
	input logic headValid,
	input exPkg::exStageEntry head,
	output logic headReady,
	output logic memStart,
	output logic memIsWrite,
	output logic [exPkg::addrW-1:0] memAddr,
	output logic [exPkg::dataW-1:0] memWdata,
	input logic memDone,
	input logic memError,
	input logic [exPkg::dataW-1:0] memRdata,
	output logic retireValid,
	output exPkg::exRetire retireData,
	input logic retireReady,
	output logic writeEn,
	output logic [exPkg::regIdW-1:0] writeId,
	output logic [exPkg::dataW-1:0] writeVal,
	output logic tWrite,
	output logic tValue,
	output logic clearEn,
	output logic [exPkg::regIdW-1:0] clearId,
	output logic clearT
);

	logic [exPkg::holdW-1:0] holdCyc; // Cycles spent at this head
	logic memFinished; // Done seen while retire was blocked
	logic isMem;
	logic opDone;
	logic push;
	logic signed [32:0] mulA;
	logic signed [32:0] mulB;
	logic signed [65:0] mulFull;
	logic [63:0] mulProd;
	logic [exPkg::dataW-1:0] mulResult;

	assign isMem = head.cmd inside {exPkg::MOV_RM, exPkg::MOV_MR};
	assign memStart = headValid && isMem && holdCyc == '0; // Once per head
	assign memIsWrite = head.cmd == exPkg::MOV_RM;
	assign memAddr = head.memAddr;
	assign memWdata = head.storeData;

	always_comb begin
		case (head.cmd)
			exPkg::MUL3: opDone = holdCyc >= exPkg::holdW'(exPkg::mulCycles);
			exPkg::MOV_RM, exPkg::MOV_MR: opDone = memFinished || memDone;
			default: opDone = 1'b1;
		endcase
	end

	assign retireValid = headValid && opDone;
	assign headReady = opDone && retireReady; // Full retire queue holds EX2
	assign push = retireValid && retireReady;

	// One 33x33 signed multiplier covers signed and unsigned forms
	always_comb begin
		mulA = {!head.ixt[0] && head.operandA[31], head.operandA[31:0]};
		mulB = {!head.ixt[0] && head.operandB[31], head.operandB[31:0]};
		mulFull = mulA * mulB;
	end

	always_comb begin
		case (head.ixt)
			2'b00: mulResult = {{32{mulProd[31]}}, mulProd[31:0]};
			2'b01: mulResult = {32'b0, mulProd[31:0]};
			2'b10: mulResult = {{32{mulProd[63]}}, mulProd[63:32]};
			default: mulResult = {32'b0, mulProd[63:32]};
		endcase
	end

	always_comb begin
		retireData = '0;
		retireData.cmd = head.cmd;
		retireData.regId = head.rm;
		retireData.tWrite = head.tWriteEn;
		retireData.tValue = head.newT;
		retireData.fault = !exPkg::isKnown(head.origCmd) || (isMem && memError);
		case (head.cmd)
			exPkg::MOV_IR, exPkg::ALU3: retireData.value = head.aluResult;
			exPkg::MUL3: retireData.value = mulResult;
			exPkg::MOV_MR: retireData.value = memRdata;
			default: ;
		endcase
		retireData.writes = exPkg::writesReg(head.cmd) && !retireData.fault;
	end

	assign writeEn = push && retireData.writes;
	assign writeId = head.rm;
	assign writeVal = retireData.value;
	assign tWrite = push && head.tWriteEn;
	assign tValue = head.newT;
	assign clearEn = push && exPkg::writesReg(head.cmd); // Faulted loads clear too
	assign clearId = head.rm;
	assign clearT = push && head.tWriteEn;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			holdCyc <= '0;
			memFinished <= 1'b0;
		end else begin
			if (headValid && headReady) begin
				holdCyc <= '0;
				memFinished <= 1'b0;
			end else begin
				if (headValid && holdCyc != '1)
					holdCyc <= holdCyc + 1'b1; // Saturates so start never repeats
				if (memDone)
					memFinished <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		mulProd <= mulFull[63:0];
	end

endmodule

/* design/exBackEnd.sv */
/*
 Execute back end top
 EX1 issue, stage queue, EX2 completion, retire queue and AXI4-Lite master
*/
`timescale 1ns/1ns
module exBackEnd (
	input logic clock,
	input logic arstN,
	input logic uopValid,
	input exPkg::exUop uop,
	output logic uopReady,
	output logic retireValid,
	output exPkg::exRetire retire,
	input logic retireReady,
	output exPkg::axiLiteReq memReq,
	input exPkg::axiLiteRsp memRsp
);

	logic [exPkg::regIdW-1:0] readIdA;
	logic [exPkg::regIdW-1:0] readIdB;
	logic [exPkg::regIdW-1:0] readIdC;
	logic [exPkg::dataW-1:0] readValA;
	logic [exPkg::dataW-1:0] readValB;
	logic [exPkg::dataW-1:0] readValC;
	logic tFlag;
	logic stageValid;
	exPkg::exStageEntry stageEntry;
	logic stageReady;
	logic headValid;
	exPkg::exStageEntry head;
	logic headReady;
	logic memStart;
	logic memIsWrite;
	logic [exPkg::addrW-1:0] memAddr;
	logic [exPkg::dataW-1:0] memWdata;
	logic memDone;
	logic memError;
	logic [exPkg::dataW-1:0] memRdata;
	logic retPushValid;
	exPkg::exRetire retPushData;
	logic retPushReady;
	logic writeEn;
	logic [exPkg::regIdW-1:0] writeId;
	logic [exPkg::dataW-1:0] writeVal;
	logic tWrite;
	logic tValue;
	logic clearEn;
	logic [exPkg::regIdW-1:0] clearId;
	logic clearT;

	exRegFile i_regFile (.clock, .arstN, .readIdA, .readIdB, .readIdC,
		.readValA, .readValB, .readValC, .tFlag, .writeEn, .writeId, .writeVal,
		.tWrite, .tValue);

	exIssue i_issue (.clock, .arstN, .uopValid, .uop, .uopReady,
		.readIdA, .readIdB, .readIdC, .readValA, .readValB, .readValC, .tFlag,
		.stageValid, .stageEntry, .stageReady, .clearEn, .clearId, .clearT);

	exStageQueue #(.payloadT(exPkg::exStageEntry), .depth(exPkg::stageDepth)) i_stageQueue (
		.clock, .arstN, .inValid(stageValid), .inData(stageEntry), .inReady(stageReady),
		.outValid(headValid), .outData(head), .outReady(headReady));

	exComplete i_complete (.clock, .arstN, .headValid, .head, .headReady,
		.memStart, .memIsWrite, .memAddr, .memWdata, .memDone, .memError, .memRdata,
		.retireValid(retPushValid), .retireData(retPushData), .retireReady(retPushReady),
		.writeEn, .writeId, .writeVal, .tWrite, .tValue, .clearEn, .clearId, .clearT);

	exStageQueue #(.payloadT(exPkg::exRetire), .depth(exPkg::retireDepth)) i_retireQueue (
		.clock, .arstN, .inValid(retPushValid), .inData(retPushData),
		.inReady(retPushReady), .outValid(retireValid), .outData(retire), .outReady(retireReady));

	exMemMaster i_memMaster (.clock, .arstN, .start(memStart), .isWrite(memIsWrite),
		.addr(memAddr), .wdata(memWdata), .done(memDone), .error(memError),
		.rdata(memRdata), .memReq, .memRsp);

endmodule

/* sim/exBackEnd_props.sv */
/*
 Execute back end properties
 AXI and retire handshake stability, single outstanding memory use, reset state
*/
`timescale 1ns/1ns
module exBackEnd_props (
	input logic clock,
	input logic arstN,
	input logic uopReady,
	input logic retireValid,
	input exPkg::exRetire retire,
	input logic retireReady,
	input exPkg::axiLiteReq memReq,
	input exPkg::axiLiteRsp memRsp
);

	logic busy;

	assign busy = memReq.bready || memReq.rready; // Master waiting on B or R

	awStable: assert property (@(posedge clock) disable iff (!arstN)
		memReq.awvalid && !memRsp.awready |=> memReq.awvalid && $stable(memReq.awaddr))
		else $error("AW dropped or changed before awready");

	wStable: assert property (@(posedge clock) disable iff (!arstN)
		memReq.wvalid && !memRsp.wready |=> memReq.wvalid && $stable(memReq.wdata))
		else $error("W dropped or changed before wready");

	arStable: assert property (@(posedge clock) disable iff (!arstN)
		memReq.arvalid && !memRsp.arready |=> memReq.arvalid && $stable(memReq.araddr))
		else $error("AR dropped or changed before arready");

	retireStable: assert property (@(posedge clock) disable iff (!arstN)
		retireValid && !retireReady |=> retireValid && $stable(retire))
		else $error("Retire record dropped or changed while stalled");

	singleOutstanding: assert property (@(posedge clock) disable iff (!arstN)
		$rose(memReq.arvalid) || $rose(memReq.awvalid) |-> !$past(busy))
		else $error("New AXI request while a transaction is outstanding");

	resetQuiet: assert property (@(posedge clock)
		!arstN |-> !uopReady && !retireValid && !memReq.awvalid && !memReq.wvalid
			&& !memReq.arvalid && !memReq.bready && !memReq.rready)
		else $error("Control output high during reset");

endmodule

bind exBackEnd exBackEnd_props i_props (.*);

/* sim/exBackEndTb.sv */
/*
 Execute back end testbench
 Random program checked against an in-order reference model,
 AXI4-Lite memory responder with random delays, random retire back-pressure
*/
`timescale 1ns/1ns
module exBackEndTb;

	localparam int numUops = 300;
	localparam int timeoutCycles = numUops * 40 + 100; // Worst case per uop plus margin
	localparam logic [31:0] memBase = 32'h0000_2000; // 256-byte window
	localparam logic [1:0] slvErr = 2'b10;

	logic clock;
	logic arstN;
	logic uopValid;
	exPkg::exUop uop;
	logic uopReady;
	logic retireValid;
	exPkg::exRetire retire;
	logic retireReady;
	exPkg::axiLiteReq memReq;
	exPkg::axiLiteRsp memRsp;

	integer uopSeed; // One stream per process
	integer memSeed;
	integer retSeed;
	logic [63:0] modelRegs [16];
	logic modelT;
	logic [63:0] modelMem [logic [31:0]];
	logic [63:0] respMem [logic [31:0]]; // Responder's own copy
	exPkg::exRetire expQ [$];
	logic [31:0] storeAddrQ [$];
	logic [63:0] storeDataQ [$];
	logic [31:0] loadAddrQ [$];
	int retiredCount;
	int cycleCount;

	exBackEnd i_exBackEnd (.clock, .arstN, .uopValid, .uop, .uopReady,
		.retireValid, .retire, .retireReady, .memReq, .memRsp);

	initial begin
		clock = 1'b0;
		forever #4 clock = !clock;
	end

	function automatic int unsigned pick(inout integer s, input int unsigned n);
		return $unsigned($random(s)) % n;
	endfunction

	task automatic stopRun();
		$display("Testbench failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic checkRetire(input exPkg::exRetire got, input exPkg::exRetire exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t retire got %h expected %h", $time, got, exp);
			stopRun();
		end
	endtask

	task automatic checkMemWrite(input logic [exPkg::addrW-1:0] gotAddr,
		input logic [exPkg::addrW-1:0] expAddr, input logic [exPkg::dataW-1:0] gotData,
		input logic [exPkg::dataW-1:0] expData, input logic [exPkg::dataW/8-1:0] gotStrb);
		logic [exPkg::dataW/8-1:0] expStrb;
		expStrb = '1; // Full-word stores only
		if (gotAddr !== expAddr || gotData !== expData || gotStrb !== expStrb) begin
			$display("MISMATCH time %0t awaddr/wdata/wstrb got %h/%h/%h expected %h/%h/%h",
				$time, gotAddr, gotData, gotStrb, expAddr, expData, expStrb);
			stopRun();
		end
	endtask

	task automatic checkMemRead(input logic [exPkg::addrW-1:0] got,
		input logic [exPkg::addrW-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time %0t araddr got %h expected %h", $time, got, exp);
			stopRun();
		end
	endtask

	// Draws one uop, memory imm aimed into the window from the current rs value
	task automatic makeUop(output exPkg::exUop u);
		int unsigned kind;
		logic [31:0] target;
		u = '0;
		kind = pick(uopSeed, 16);
		u.rs = 4'(pick(uopSeed, 16));
		u.rt = 4'(pick(uopSeed, 16));
		u.rm = 4'(pick(uopSeed, 16));
		u.ixt = 2'(pick(uopSeed, 4));
		u.cond = (pick(uopSeed, 10) < 6) ? 2'b00 : 2'(pick(uopSeed, 4));
		u.imm = (pick(uopSeed, 4) == 0) ? 32'(pick(uopSeed, 4)) : $random(uopSeed);
		case (kind)
			0: u.cmd = exPkg::NOP;
			1, 2, 3: u.cmd = exPkg::MOV_IR;
			4, 5, 6: u.cmd = exPkg::ALU3;
			7, 8: begin
				u.cmd = exPkg::ALUCMP;
				u.ixt[1] = 1'b0; // Equal or signed greater
			end
			9, 10: u.cmd = exPkg::MUL3;
			11, 12: u.cmd = exPkg::MOV_RM;
			13, 14: u.cmd = exPkg::MOV_MR;
			default: u.cmd = exPkg::exCmd'(4'(7 + pick(uopSeed, 9))); // Unhandled codes
		endcase
		if (u.cmd inside {exPkg::MOV_RM, exPkg::MOV_MR}) begin
			target = memBase + 32'(pick(uopSeed, 16) * 8) + 32'(pick(uopSeed, 8));
			if (pick(uopSeed, 6) == 0)
				target = target + 32'h80; // Bit 7 answers SLVERR
			u.imm = target - modelRegs[u.rs][31:0];
		end
	endtask

	// Reference step in program order at accept
	task automatic modelAccept(input exPkg::exUop u);
		exPkg::exRetire e;
		logic predOk;
		logic [63:0] a;
		logic [63:0] b;
		logic [31:0] sum;
		logic [31:0] addr;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0] prodS;
		logic [63:0] prodU;
		case (u.cond)
			2'b00: predOk = 1'b1;
			2'b01: predOk = 1'b0;
			2'b10: predOk = modelT;
			default: predOk = !modelT;
		endcase
		a = modelRegs[u.rs];
		b = modelRegs[u.rt];
		sum = a[31:0] + u.imm;
		addr = {sum[31:3], 3'b000};
		sa = {{32{a[31]}}, a[31:0]};
		sb = {{32{b[31]}}, b[31:0]};
		prodS = sa * sb;
		prodU = {32'b0, a[31:0]} * {32'b0, b[31:0]};
		e = '0;
		e.cmd = predOk ? u.cmd : exPkg::NOP;
		e.regId = u.rm;
		e.fault = !(u.cmd inside {exPkg::NOP, exPkg::MOV_IR, exPkg::ALU3, exPkg::ALUCMP,
			exPkg::MUL3, exPkg::MOV_RM, exPkg::MOV_MR});
		if (predOk) begin
			case (u.cmd)
				exPkg::MOV_IR: e.value = {{32{u.imm[31]}}, u.imm};
				exPkg::ALU3: begin
					case (u.ixt)
						2'b00: e.value = a + b;
						2'b01: e.value = a - b;
						2'b10: e.value = a & b;
						default: e.value = a ^ b;
					endcase
				end
				exPkg::ALUCMP: begin
					e.tWrite = 1'b1;
					e.tValue = u.ixt[0] ? ($signed(a) > $signed(b)) : (a == b);
				end
				exPkg::MUL3: begin
					case (u.ixt)
						2'b00: e.value = {{32{prodS[31]}}, prodS[31:0]};
						2'b01: e.value = {32'b0, prodU[31:0]};
						2'b10: e.value = {{32{prodS[63]}}, prodS[63:32]};
						default: e.value = {32'b0, prodU[63:32]};
					endcase
				end
				exPkg::MOV_RM: begin
					e.fault = addr[7];
					storeAddrQ.push_back(addr);
					storeDataQ.push_back(modelRegs[u.rm]);
					if (!addr[7])
						modelMem[addr] = modelRegs[u.rm];
				end
				exPkg::MOV_MR: begin
					e.fault = addr[7];
					loadAddrQ.push_back(addr);
					if (!addr[7] && modelMem.exists(addr))
						e.value = modelMem[addr]; // Never written reads 0
				end
				default: ;
			endcase
			e.writes = (u.cmd inside {exPkg::MOV_IR, exPkg::ALU3, exPkg::MUL3, exPkg::MOV_MR})
				&& !e.fault;
		end
		if (e.writes)
			modelRegs[u.rm] = e.value;
		if (e.tWrite)
			modelT = e.tValue;
		expQ.push_back(e);
	endtask

	// Program driver
	initial begin
		exPkg::exUop u;
		bit accepted;
		uopSeed = 32'ha0cb;
		memSeed = 32'ha0cb ^ 32'h1;
		retSeed = 32'ha0cb ^ 32'h2;
		arstN = 1'b0;
		uopValid = 1'b0;
		uop = '0;
		retireReady = 1'b0;
		memRsp = '0;
		modelT = 1'b0;
		retiredCount = 0;
		for (int i = 0; i < 16; i++) begin
			modelRegs[i] = '0;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		for (int n = 0; n < numUops; n++) begin
			repeat (pick(uopSeed, 3)) @(negedge clock); // Idle gap
			makeUop(u);
			uop = u;
			uopValid = 1'b1;
			accepted = 1'b0;
			while (!accepted) begin
				#2; // uopReady settled after drive
				if (uopReady) begin
					accepted = 1'b1;
					modelAccept(u);
				end
				@(negedge clock);
			end
			uopValid = 1'b0;
		end
		wait (retiredCount == numUops);
		@(negedge clock);
		if (expQ.size() == 0 && storeAddrQ.size() == 0 && loadAddrQ.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Expected records or memory accesses were left over at the end");
			stopRun();
		end
	end

	// Retire consumer with random back-pressure
	initial begin
		@(posedge arstN);
		forever begin
			@(negedge clock);
			retireReady = pick(retSeed, 10) < 7;
			#1;
			if (retireValid && retireReady) begin
				if (expQ.size() == 0) begin
					$display("Retire record at time %0t without an accepted uop", $time);
					stopRun();
				end
				checkRetire(retire, expQ.pop_front());
				retiredCount++;
			end
		end
	end

	// AXI4-Lite memory responder
	initial begin
		bit haveAw;
		bit haveW;
		bit haveAr;
		bit bDone;
		bit rDone;
		int unsigned bWait;
		int unsigned rWait;
		logic [31:0] wrAddr;
		logic [63:0] wrData;
		logic [exPkg::dataW/8-1:0] wrStrb;
		logic [31:0] rdAddr;
		haveAw = 1'b0;
		haveW = 1'b0;
		haveAr = 1'b0;
		bDone = 1'b0;
		rDone = 1'b0;
		bWait = 0;
		rWait = 0;
		@(posedge arstN);
		forever begin
			@(negedge clock);
			if (bDone)
				memRsp.bvalid = 1'b0;
			if (rDone)
				memRsp.rvalid = 1'b0;
			bDone = 1'b0;
			rDone = 1'b0;
			if (haveAw && haveW && !memRsp.bvalid) begin
				if (bWait == 0) begin
					memRsp.bvalid = 1'b1;
					memRsp.bresp = wrAddr[7] ? slvErr : 2'b00;
				end else begin
					bWait--;
				end
			end
			if (haveAr && !memRsp.rvalid) begin
				if (rWait == 0) begin
					memRsp.rvalid = 1'b1;
					memRsp.rresp = rdAddr[7] ? slvErr : 2'b00;
					memRsp.rdata = (rdAddr[7] || !respMem.exists(rdAddr)) ? '0 : respMem[rdAddr];
				end else begin
					rWait--;
				end
			end
			memRsp.awready = !haveAw && pick(memSeed, 2) != 0;
			memRsp.wready = !haveW && pick(memSeed, 2) != 0;
			memRsp.arready = !haveAr && pick(memSeed, 2) != 0;
			if (memReq.awvalid && memRsp.awready) begin
				haveAw = 1'b1;
				wrAddr = memReq.awaddr;
				bWait = pick(memSeed, 3);
			end
			if (memReq.wvalid && memRsp.wready) begin
				haveW = 1'b1;
				wrData = memReq.wdata;
				wrStrb = memReq.wstrb;
				bWait = pick(memSeed, 3);
			end
			if (memReq.arvalid && memRsp.arready) begin
				haveAr = 1'b1;
				rdAddr = memReq.araddr;
				rWait = pick(memSeed, 4);
				if (loadAddrQ.size() == 0) begin
					$display("AXI read at time %0t with no load in the program", $time);
					stopRun();
				end
				checkMemRead(rdAddr, loadAddrQ.pop_front());
			end
			if (memRsp.bvalid && memReq.bready) begin
				bDone = 1'b1;
				haveAw = 1'b0;
				haveW = 1'b0;
				if (storeAddrQ.size() == 0) begin
					$display("AXI write at time %0t with no store in the program", $time);
					stopRun();
				end
				checkMemWrite(wrAddr, storeAddrQ.pop_front(), wrData, storeDataQ.pop_front(),
					wrStrb);
				if (!wrAddr[7])
					respMem[wrAddr] = wrData;
			end
			if (memRsp.rvalid && memReq.rready) begin
				rDone = 1'b1;
				haveAr = 1'b0;
			end
		end
	end

	// Watchdog
	initial begin
		cycleCount = 0;
		forever begin
			@(posedge clock);
			cycleCount++;
			if (cycleCount >= timeoutCycles) begin
				$display("Timeout after %0d cycles with %0d of %0d uops retired",
					cycleCount, retiredCount, numUops);
				stopRun();
			end
		end
	end

endmodule

/* exBackEnd.f */
design/exPkg.sv
design/exRegFile.sv
design/exIssue.sv
design/exStageQueue.sv
design/exMemMaster.sv
design/exComplete.sv
design/exBackEnd.sv
sim/exBackEnd_props.sv
sim/exBackEndTb.sv

/* Bender.yml */
package:
  name: exBackEnd

sources:
  - files:
      - design/exPkg.sv
      - design/exRegFile.sv
      - design/exIssue.sv
      - design/exStageQueue.sv
      - design/exMemMaster.sv
      - design/exComplete.sv
      - design/exBackEnd.sv
  - target: simulation
    files:
      - sim/exBackEnd_props.sv
      - sim/exBackEndTb.sv
